// File: axi_bram_responder.f
+incdir+include
verilog/bram_rsp_pkg.sv
verilog/bram_store.sv
verilog/bram_write_channel.sv
verilog/bram_read_channel.sv
verilog/axi_bram_responder.sv
tb/tb_clock_gen.sv
tb/tb_axi_bram_responder.sv

// File: include/bram_rsp_defs.svh
`ifndef BRAM_RSP_DEFS_SVH
`define BRAM_RSP_DEFS_SVH

// ----------------------------------------------------------------------
// data path
// ----------------------------------------------------------------------
`define BRAM_RSP_DATA_W     64      // one memory word per beat
`define BRAM_RSP_STRB_W     8       // one strobe per byte lane

// ----------------------------------------------------------------------
// addressing
// ----------------------------------------------------------------------
`define BRAM_RSP_ADDR_W     12      // axi byte address
`define BRAM_RSP_WORD_W     9       // 512 words
`define BRAM_RSP_BLOCK_W    5       // top word bits, 16-word blocks

// ----------------------------------------------------------------------
// transaction fields
// ----------------------------------------------------------------------
`define BRAM_RSP_ID_W       8
`define BRAM_RSP_LEN_W      4       // beats minus one, max 16 beats
`define BRAM_RSP_RESP_OKAY  2'b00

`endif

// File: run_sim.sh
#!/usr/bin/env bash
# build the testbench with Verilator, run it, then scan the log

set -u

cd "$(dirname "$0")" || exit 1

TOP=tb_axi_bram_responder
LOG=sim.log

verilator --binary --timing --assert -j 0 \
   --top-module "$TOP" -f axi_bram_responder.f -o "$TOP"
build_status=$?
if [ "$build_status" -ne 0 ]; then
   echo "verilator build failed with status $build_status"
   exit 1
fi

"./obj_dir/$TOP" > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Checks failed" "$LOG"; then
   echo "RESULT: FAIL (see $LOG)"
   exit 1
fi

if [ "$run_status" -ne 0 ]; then
   echo "simulation exited with status $run_status"
   exit 1
fi

echo "RESULT: PASS"
exit 0

// File: tb/tb_axi_bram_responder.sv
`timescale 1ns/1ps
`include "bram_rsp_defs.svh"

module tb_axi_bram_responder;

   // beats per test: 1+1, 16+16, 4+4, 8, 8+8
   localparam int TEST_BEATS     = 66;
   localparam int TIMEOUT_CYCLES = TEST_BEATS * 40 + 500;

   logic                      clk;
   logic                      reset_n;
   logic                      aw_valid;
   logic                      aw_ready;
   bram_rsp_pkg::aw_req_t     aw;
   logic                      w_valid;
   logic                      w_ready;
   bram_rsp_pkg::w_beat_t     w;
   logic                      b_valid;
   logic                      b_ready;
   bram_rsp_pkg::b_rsp_t      b;
   logic                      ar_valid;
   logic                      ar_ready;
   bram_rsp_pkg::ar_req_t     ar;
   logic                      r_valid;
   logic                      r_ready;
   bram_rsp_pkg::r_beat_t     r;

   logic [7:0]                ref_mem [0:511][0:7];   // byte model of the store
   bram_rsp_pkg::data_t       burst_data [0:15];
   bram_rsp_pkg::strb_t       burst_strb [0:15];
   logic [31:0]               rng_state = 32'd16644;
   logic                      w_started;              // first W beat of a burst taken
   int                        cycle_count;

   tb_clock_gen u_clock (
      .o_clk     (clk),
      .o_reset_n (reset_n)
   );

   axi_bram_responder dut_i (
      .i_clk      (clk),
      .i_reset_n  (reset_n),
      .i_aw_valid (aw_valid),
      .o_aw_ready (aw_ready),
      .i_aw       (aw),
      .i_w_valid  (w_valid),
      .o_w_ready  (w_ready),
      .i_w        (w),
      .o_b_valid  (b_valid),
      .i_b_ready  (b_ready),
      .o_b        (b),
      .i_ar_valid (ar_valid),
      .o_ar_ready (ar_ready),
      .i_ar       (ar),
      .o_r_valid  (r_valid),
      .i_r_ready  (r_ready),
      .o_r        (r)
   );

   // ----------------------------------------------------------------------
   // helpers
   // ----------------------------------------------------------------------
   function automatic logic [31:0] next_random();
      logic [31:0] x;
      x = rng_state;
      x = x ^ (x << 13);
      x = x ^ (x >> 17);
      x = x ^ (x << 5);
      rng_state = x;
      return x;
   endfunction

   // byte address / 8 plus beat, wraps at 512 words
   function automatic bram_rsp_pkg::word_addr_t beat_word(input bram_rsp_pkg::axi_addr_t addr,
                                                          input int beat);
      int wd;
      wd = (int'(addr) / 8 + beat) % 512;
      return wd[8:0];
   endfunction

   function automatic bram_rsp_pkg::data_t model_read(input bram_rsp_pkg::word_addr_t word);
      bram_rsp_pkg::data_t d;
      for (int i = 0; i < 8; i++)
         d[i*8 +: 8] = ref_mem[word][i];
      return d;
   endfunction

   task automatic model_write(input bram_rsp_pkg::word_addr_t word,
                              input bram_rsp_pkg::data_t data, input bram_rsp_pkg::strb_t strb);
      for (int i = 0; i < 8; i++)
      begin
         if (strb[i])
            ref_mem[word][i] = data[i*8 +: 8];   // untouched lanes keep old bytes
      end
   endtask

   task automatic next_cycle();
      @(posedge clk);
      #2;
   endtask

   task automatic fail_run(input string why);
      $display("%s", why);
      $display("Checks failed");
      $fatal(1);
   endtask

   // ----------------------------------------------------------------------
   // compare tasks
   // ----------------------------------------------------------------------
   task automatic check_data(input string name, input bram_rsp_pkg::data_t got,
                             input bram_rsp_pkg::data_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_id(input string name, input bram_rsp_pkg::axi_id_t got,
                           input bram_rsp_pkg::axi_id_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %h expected %h", $time, name, got, exp));
   endtask

   task automatic check_resp(input string name, input bram_rsp_pkg::resp_t got,
                             input bram_rsp_pkg::resp_t exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   task automatic check_last(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   // handshake flags
   task automatic check_flag(input string name, input logic got, input logic exp);
      if (got !== exp)
         fail_run($sformatf("mismatch at %0t: %s got %b expected %b", $time, name, got, exp));
   endtask

   // ----------------------------------------------------------------------
   // stimulus
   // ----------------------------------------------------------------------
   task automatic check_reset_release();
      // all handshake outputs quiet out of reset
      check_flag("o_aw_ready", aw_ready, 1'b0);
      check_flag("o_w_ready", w_ready, 1'b0);
      check_flag("o_ar_ready", ar_ready, 1'b0);
      check_flag("o_r_valid", r_valid, 1'b0);
      check_flag("o_b_valid", b_valid, 1'b0);
      next_cycle();
      check_flag("o_aw_ready", aw_ready, 1'b1);   // readies one cycle later
      check_flag("o_w_ready", w_ready, 1'b1);
      check_flag("o_ar_ready", ar_ready, 1'b1);
      check_flag("o_r_valid", r_valid, 1'b0);
      check_flag("o_b_valid", b_valid, 1'b0);
   endtask

   task automatic fill_burst(input int beats, input logic partial);
      logic [31:0] hi;
      logic [31:0] lo;
      logic [31:0] s;
      for (int i = 0; i < beats; i++)
      begin
         hi = next_random();
         lo = next_random();
         s  = next_random();
         burst_data[i] = {hi, lo};
         burst_strb[i] = partial ? ((s[7:0] | 8'h01) & 8'h7F) : 8'hFF;   // lane 7 stays old
      end
   endtask

   task automatic write_burst(input bram_rsp_pkg::axi_id_t id,
                              input bram_rsp_pkg::axi_addr_t addr, input int beats);
      w_started = 1'b0;
      aw_valid  = 1'b1;
      aw        = '{id: id, addr: addr, len: bram_rsp_pkg::burst_len_t'(beats - 1)};
      while (!aw_ready)
         next_cycle();
      next_cycle();                              // AW taken at that edge
      aw_valid = 1'b0;
      for (int i = 0; i < beats; i++)
      begin
         w_valid = 1'b1;
         w       = '{data: burst_data[i], strb: burst_strb[i], last: (i == beats - 1)};
         while (!w_ready)
            next_cycle();
         model_write(beat_word(addr, i), burst_data[i], burst_strb[i]);
         next_cycle();
         if (i == 0)
            w_started = 1'b1;
      end
      w_valid = 1'b0;
   endtask

   task automatic collect_b(input bram_rsp_pkg::axi_id_t exp_id, input int hold);
      bram_rsp_pkg::b_rsp_t held;
      while (!b_valid)
         next_cycle();
      held = b;
      check_id("o_b.id", b.id, exp_id);
      check_resp("o_b.resp", b.resp, `BRAM_RSP_RESP_OKAY);
      for (int i = 0; i < hold; i++)            // bready low, B must hold
      begin
         check_flag("o_aw_ready", aw_ready, 1'b0);
         next_cycle();
         check_flag("o_b_valid", b_valid, 1'b1);
         check_id("o_b.id", b.id, held.id);
         check_resp("o_b.resp", b.resp, held.resp);
      end
      check_flag("o_aw_ready", aw_ready, 1'b0);
      b_ready = 1'b1;
      next_cycle();
      b_ready = 1'b0;
      check_flag("o_b_valid", b_valid, 1'b0);
      check_flag("o_aw_ready", aw_ready, 1'b1); // address side open again
   endtask

   task automatic read_burst(input bram_rsp_pkg::axi_id_t id,
                             input bram_rsp_pkg::axi_addr_t addr, input int beats,
                             input logic throttle);
      int                    got_cnt;
      logic                  stalled;
      logic [31:0]           rnd;
      bram_rsp_pkg::r_beat_t held;
      ar_valid = 1'b1;
      ar       = '{id: id, addr: addr, len: bram_rsp_pkg::burst_len_t'(beats - 1)};
      while (!ar_ready)
         next_cycle();
      next_cycle();
      ar_valid = 1'b0;
      got_cnt  = 0;
      stalled  = 1'b0;
      while (got_cnt < beats)
      begin
         check_flag("o_ar_ready", ar_ready, 1'b0);   // closed until the last beat
         if (stalled)                           // parked beat must not move
         begin
            check_flag("o_r_valid", r_valid, 1'b1);
            check_data("o_r.data", r.data, held.data);
            check_id("o_r.id", r.id, held.id);
            check_resp("o_r.resp", r.resp, held.resp);
            check_last("o_r.last", r.last, held.last);
         end
         rnd     = next_random();
         r_ready = throttle ? rnd[0] : 1'b1;
         if (r_valid && r_ready)
         begin
            check_data("o_r.data", r.data, model_read(beat_word(addr, got_cnt)));
            check_id("o_r.id", r.id, id);
            check_resp("o_r.resp", r.resp, `BRAM_RSP_RESP_OKAY);
            check_last("o_r.last", r.last, (got_cnt == beats - 1));
            got_cnt++;
            stalled = 1'b0;
         end
         else if (r_valid)
         begin
            stalled = 1'b1;
            held    = r;
         end
         next_cycle();
      end
      r_ready = 1'b0;
   endtask

   // ----------------------------------------------------------------------
   // test sequence
   // ----------------------------------------------------------------------
   initial
   begin
      int hold;
      logic [31:0] rnd;
      aw_valid  = 1'b0;
      aw        = '0;
      w_valid   = 1'b0;
      w         = '0;
      b_ready   = 1'b0;
      ar_valid  = 1'b0;
      ar        = '0;
      r_ready   = 1'b0;
      w_started = 1'b0;
      wait (reset_n);
      check_reset_release();

      $display("test 1: single beat write and read");
      fill_burst(1, 1'b0);
      write_burst(8'h21, 12'h008, 1);
      collect_b(8'h21, 0);
      read_burst(8'h35, 12'h008, 1, 1'b0);

      $display("test 2: 16 beat burst");
      fill_burst(16, 1'b0);
      write_burst(8'h42, 12'h100, 16);          // words 0x20..0x2f
      collect_b(8'h42, 2);
      read_burst(8'h43, 12'h100, 16, 1'b0);

      $display("test 3: partial strobes");
      fill_burst(4, 1'b1);
      write_burst(8'h5a, 12'h110, 4);           // over words from test 2
      collect_b(8'h5a, 1);
      read_burst(8'h5b, 12'h110, 4, 1'b0);

      $display("test 4: R back-pressure");
      read_burst(8'h66, 12'h140, 8, 1'b1);

      $display("test 5: B back-pressure with overlapping read");
      rnd  = next_random();
      hold = 3 + int'(rnd % 32'd10);
      fill_burst(8, 1'b0);
      w_started = 1'b0;                         // read waits for this burst's first beat
      fork
         write_burst(8'h77, 12'h200, 8);        // block 4, words 0x40..0x47
         begin
            wait (w_started);
            read_burst(8'h78, 12'h200, 8, 1'b0);
         end
         collect_b(8'h77, hold);
      join

      $display("All checks passed");
      $finish;
   end

   // run limit from the test lengths
   initial
   begin
      cycle_count = 0;
      while (cycle_count < TIMEOUT_CYCLES)
      begin
         @(posedge clk);
         cycle_count++;
      end
      fail_run($sformatf("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES));
   end

endmodule

// File: tb/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
   output logic o_clk,
   output logic o_reset_n
);

   localparam int HALF_PERIOD = 10;   // 20 ns clock
   localparam int RESET_CYCLES = 8;

   initial
   begin
      o_clk     = 1'b0;
      o_reset_n = 1'b0;
      repeat (RESET_CYCLES) @(posedge o_clk);
      #2;                              // same skew as the stimulus
      o_reset_n = 1'b1;
   end

   always
   begin
      #(HALF_PERIOD) o_clk = ~o_clk;
   end

endmodule

// File: verilog/axi_bram_responder.sv
`timescale 1ns/1ps

module axi_bram_responder (
   input  logic                    i_clk,
   input  logic                    i_reset_n,
   // write address
   input  logic                    i_aw_valid,
   output logic                    o_aw_ready,
   input  bram_rsp_pkg::aw_req_t   i_aw,
   // write data
   input  logic                    i_w_valid,
   output logic                    o_w_ready,
   input  bram_rsp_pkg::w_beat_t   i_w,
   // write response
   output logic                    o_b_valid,
   input  logic                    i_b_ready,
   output bram_rsp_pkg::b_rsp_t    o_b,
   // read address
   input  logic                    i_ar_valid,
   output logic                    o_ar_ready,
   input  bram_rsp_pkg::ar_req_t   i_ar,
   // read data
   output logic                    o_r_valid,
   input  logic                    i_r_ready,
   output bram_rsp_pkg::r_beat_t   o_r
);

   bram_rsp_pkg::mem_wr_t     mem_wr;    // write port into store
   logic                      rd_en;
   bram_rsp_pkg::word_addr_t  rd_addr;
   bram_rsp_pkg::data_t       rd_data;   // two cycles after rd_en
   bram_rsp_pkg::block_busy_t wr_busy;   // write -> read
   bram_rsp_pkg::block_busy_t rd_busy;   // read -> write

   bram_write_channel u_write (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_aw_valid (i_aw_valid),
      .o_aw_ready (o_aw_ready),
      .i_aw       (i_aw),
      .i_w_valid  (i_w_valid),
      .o_w_ready  (o_w_ready),
      .i_w        (i_w),
      .o_b_valid  (o_b_valid),
      .i_b_ready  (i_b_ready),
      .o_b        (o_b),
      .o_mem_wr   (mem_wr),
      .i_rd_busy  (rd_busy),
      .o_wr_busy  (wr_busy)
   );

   bram_read_channel u_read (
      .i_clk      (i_clk),
      .i_reset_n  (i_reset_n),
      .i_ar_valid (i_ar_valid),
      .o_ar_ready (o_ar_ready),
      .i_ar       (i_ar),
      .o_r_valid  (o_r_valid),
      .i_r_ready  (i_r_ready),
      .o_r        (o_r),
      .o_rd_en    (rd_en),
      .o_rd_addr  (rd_addr),
      .i_rd_data  (rd_data),
      .i_wr_busy  (wr_busy),
      .o_rd_busy  (rd_busy)
   );

   bram_store u_store (
      .i_clk      (i_clk),
      .i_mem_wr   (mem_wr),
      .i_rd_en    (rd_en),
      .i_rd_addr  (rd_addr),
      .o_rd_data  (rd_data)
   );

endmodule

// File: verilog/bram_read_channel.sv
`timescale 1ns/1ps
`include "bram_rsp_defs.svh"

module bram_read_channel (
   input  logic                      i_clk,
   input  logic                      i_reset_n,
   input  logic                      i_ar_valid,
   output logic                      o_ar_ready,
   input  bram_rsp_pkg::ar_req_t     i_ar,
   output logic                      o_r_valid,
   input  logic                      i_r_ready,
   output bram_rsp_pkg::r_beat_t     o_r,
   output logic                      o_rd_en,
   output bram_rsp_pkg::word_addr_t  o_rd_addr,
   input  bram_rsp_pkg::data_t       i_rd_data,
   input  bram_rsp_pkg::block_busy_t i_wr_busy,
   output bram_rsp_pkg::block_busy_t o_rd_busy
);

   bram_rsp_pkg::rd_state_e  rd_state;
   bram_rsp_pkg::word_addr_t rd_addr;      // next word to fetch
   bram_rsp_pkg::burst_len_t rd_len;       // beats left minus one
   bram_rsp_pkg::axi_id_t    rd_id;
   bram_rsp_pkg::block_t     rd_block;
   logic                     rd_more;      // still issuing
   logic                     ar_hs;
   logic                     r_pop;
   logic                     push;
   logic [1:0]               pipe_vld;     // memory latency stages
   logic [1:0]               pipe_last;
   bram_rsp_pkg::data_t      buf_data [2];
   logic [1:0]               buf_last;
   logic                     wr_ptr;
   logic                     rd_ptr;
   logic [1:0]               buf_cnt;
   logic [2:0]               occ;          // pipe + buffer

   assign ar_hs    = i_ar_valid & o_ar_ready;
   assign r_pop    = o_r_valid & i_r_ready;
   assign push     = pipe_vld[1];          // data on i_rd_data this cycle
   assign rd_block = rd_addr[`BRAM_RSP_WORD_W-1 -: `BRAM_RSP_BLOCK_W];
   assign occ      = {2'b00, pipe_vld[0]} + {2'b00, pipe_vld[1]} + {1'b0, buf_cnt};

   // issue only if the beat has a buffer slot when it lands
   assign o_rd_en   = (rd_state == bram_rsp_pkg::RD_SEND) && rd_more &&
                      ((occ - {2'b00, r_pop}) < 3'd2);
   assign o_rd_addr = rd_addr;
   assign o_rd_busy = '{busy: rd_state != bram_rsp_pkg::RD_IDLE, block: rd_block};

   // R is the buffer head
   assign o_r_valid = (buf_cnt != 2'd0);
   assign o_r       = '{data: buf_data[rd_ptr], id: rd_id,
                        resp: `BRAM_RSP_RESP_OKAY, last: buf_last[rd_ptr]};

   // ----------------------------------------------------------------------
   // AR / R machine
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         rd_state   <= bram_rsp_pkg::RD_IDLE;
         o_ar_ready <= 1'b0;
         rd_more    <= 1'b0;
      end
      else
      begin
         case (rd_state)
            bram_rsp_pkg::RD_IDLE:
            begin
               o_ar_ready <= !ar_hs;
               if (ar_hs)
                  rd_state <= bram_rsp_pkg::RD_CAPTURE;
            end
            bram_rsp_pkg::RD_CAPTURE:
            begin
               // wait out a write busy in our block
               if (!(i_wr_busy.busy && (i_wr_busy.block == rd_block)))
               begin
                  rd_state <= bram_rsp_pkg::RD_SEND;
                  rd_more  <= 1'b1;
               end
            end
            bram_rsp_pkg::RD_SEND:
            begin
               if (o_rd_en && (rd_len == '0))
                  rd_more <= 1'b0;                            // last word issued
               if (r_pop && o_r.last)                         // burst done
               begin
                  rd_state   <= bram_rsp_pkg::RD_IDLE;
                  o_ar_ready <= 1'b1;
               end
            end
            default:
               rd_state <= bram_rsp_pkg::RD_IDLE;
         endcase
      end
   end

   // burst address and length counters
   always_ff @(posedge i_clk)
   begin
      if (ar_hs)
      begin
         rd_addr <= i_ar.addr[`BRAM_RSP_ADDR_W-1 -: `BRAM_RSP_WORD_W];
         rd_len  <= i_ar.len;
         rd_id   <= i_ar.id;
      end
      else if (o_rd_en)
      begin
         rd_addr <= rd_addr + 1'b1;
         rd_len  <= rd_len - 1'b1;
      end
   end

   // ----------------------------------------------------------------------
   // latency pipe, last flag rides beside the data
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      pipe_last <= {pipe_last[0], rd_len == '0};
      if (!i_reset_n)
         pipe_vld <= 2'b00;
      else
         pipe_vld <= {pipe_vld[0], o_rd_en};
   end

   // two-entry holding buffer
   always_ff @(posedge i_clk)
   begin
      if (push)
      begin
         buf_data[wr_ptr] <= i_rd_data;
         buf_last[wr_ptr] <= pipe_last[1];
      end
      if (!i_reset_n)
      begin
         wr_ptr  <= 1'b0;
         rd_ptr  <= 1'b0;
         buf_cnt <= 2'd0;
      end
      else
      begin
         if (push)
            wr_ptr <= !wr_ptr;
         if (r_pop)
            rd_ptr <= !rd_ptr;
         buf_cnt <= buf_cnt + {1'b0, push} - {1'b0, r_pop};
      end
   end

   a_r_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_r_valid && !i_r_ready) |=> (o_r_valid && $stable(o_r)));

   // issued beats never outrun the buffer
   a_in_flight : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      occ <= 3'd2);

endmodule

// File: verilog/bram_rsp_pkg.sv
`include "bram_rsp_defs.svh"

package bram_rsp_pkg;

   // vectors with a meaning of their own
   typedef logic [`BRAM_RSP_DATA_W-1:0]  data_t;
   typedef logic [`BRAM_RSP_STRB_W-1:0]  strb_t;
   typedef logic [`BRAM_RSP_ADDR_W-1:0]  axi_addr_t;
   typedef logic [`BRAM_RSP_WORD_W-1:0]  word_addr_t;
   typedef logic [`BRAM_RSP_BLOCK_W-1:0] block_t;
   typedef logic [`BRAM_RSP_ID_W-1:0]    axi_id_t;
   typedef logic [`BRAM_RSP_LEN_W-1:0]   burst_len_t;
   typedef logic [1:0]                   resp_t;

   // ----------------------------------------------------------------------
   // channel payloads
   // ----------------------------------------------------------------------
   typedef struct packed {
      axi_id_t    id;
      axi_addr_t  addr;   // byte address
      burst_len_t len;    // beats - 1
   } aw_req_t;

   typedef aw_req_t ar_req_t;   // read request, same fields

   typedef struct packed {
      data_t data;
      strb_t strb;
      logic  last;
   } w_beat_t;

   typedef struct packed {
      data_t   data;
      axi_id_t id;
      resp_t   resp;
      logic    last;
   } r_beat_t;

   typedef struct packed {
      axi_id_t id;
      resp_t   resp;
   } b_rsp_t;

   // memory write port
   typedef struct packed {
      logic       en;
      word_addr_t addr;
      data_t      data;
      strb_t      strb;
   } mem_wr_t;

   // block a channel currently holds
   typedef struct packed {
      logic   busy;
      block_t block;
   } block_busy_t;

   // ----------------------------------------------------------------------
   // state machines
   // ----------------------------------------------------------------------
   typedef enum logic {
      AW_IDLE,
      AW_CAPTURED
   } aw_state_e;

   typedef enum logic [1:0] {
      WR_IDLE,
      WR_CAPTURE,
      WR_DATA,
      WR_RSP
   } wr_state_e;

   typedef enum logic [1:0] {
      RD_IDLE,
      RD_CAPTURE,
      RD_SEND
   } rd_state_e;

endpackage

// File: verilog/bram_store.sv
`timescale 1ns/1ps
`include "bram_rsp_defs.svh"

module bram_store (
   input  logic                     i_clk,
   input  bram_rsp_pkg::mem_wr_t    i_mem_wr,
   input  logic                     i_rd_en,
   input  bram_rsp_pkg::word_addr_t i_rd_addr,
   output bram_rsp_pkg::data_t      o_rd_data
);

   localparam int DEPTH = 1 << `BRAM_RSP_WORD_W;

   bram_rsp_pkg::data_t mem [0:DEPTH-1];
   bram_rsp_pkg::data_t rd_q;      // array read register
   logic                rd_en_q;

   // ----------------------------------------------------------------------
   // write port, byte lanes under strobe
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (i_mem_wr.en)
      begin
         for (int b = 0; b < `BRAM_RSP_STRB_W; b++)
         begin
            if (i_mem_wr.strb[b])
               mem[i_mem_wr.addr][b*8 +: 8] <= i_mem_wr.data[b*8 +: 8];
         end
      end
   end

   // ----------------------------------------------------------------------
   // read port, two registers deep
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      rd_en_q <= i_rd_en;
      if (i_rd_en)
         rd_q <= mem[i_rd_addr];   // old data on same-edge write
      if (rd_en_q)
         o_rd_data <= rd_q;        // output register
   end

endmodule

// File: verilog/bram_write_channel.sv
`timescale 1ns/1ps
`include "bram_rsp_defs.svh"

module bram_write_channel (
   input  logic                      i_clk,
   input  logic                      i_reset_n,
   input  logic                      i_aw_valid,
   output logic                      o_aw_ready,
   input  bram_rsp_pkg::aw_req_t     i_aw,
   input  logic                      i_w_valid,
   output logic                      o_w_ready,
   input  bram_rsp_pkg::w_beat_t     i_w,
   output logic                      o_b_valid,
   input  logic                      i_b_ready,
   output bram_rsp_pkg::b_rsp_t      o_b,
   output bram_rsp_pkg::mem_wr_t     o_mem_wr,
   input  bram_rsp_pkg::block_busy_t i_rd_busy,
   output bram_rsp_pkg::block_busy_t o_wr_busy
);

   bram_rsp_pkg::aw_state_e  aw_state;
   bram_rsp_pkg::wr_state_e  wr_state;
   bram_rsp_pkg::word_addr_t wr_addr;     // next word of the burst
   bram_rsp_pkg::word_addr_t beat_addr;   // word for a beat taken now
   bram_rsp_pkg::block_t     beat_block;
   logic                     aw_hs;
   logic                     w_hs;
   logic                     b_hs;
   logic                     clash;       // read holds our block

   assign aw_hs = i_aw_valid & o_aw_ready;
   assign w_hs  = i_w_valid & o_w_ready;
   assign b_hs  = o_b_valid & i_b_ready;

   // first beat may come with AW itself, byte address -> word address
   assign beat_addr  = aw_hs ? i_aw.addr[`BRAM_RSP_ADDR_W-1 -: `BRAM_RSP_WORD_W] : wr_addr;
   assign beat_block = beat_addr[`BRAM_RSP_WORD_W-1 -: `BRAM_RSP_BLOCK_W];
   assign clash      = i_rd_busy.busy && (i_rd_busy.block == beat_block);

   // busy from the first beat taken until the memory has the last one
   assign o_wr_busy = '{busy:  w_hs || (wr_state == bram_rsp_pkg::WR_DATA) ||
                               ((wr_state == bram_rsp_pkg::WR_RSP) && !o_b_valid),
                        block: beat_block};

   // ----------------------------------------------------------------------
   // AW machine, one address per B
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         aw_state   <= bram_rsp_pkg::AW_IDLE;
         o_aw_ready <= 1'b0;
      end
      else
      begin
         case (aw_state)
            bram_rsp_pkg::AW_IDLE:
            begin
               o_aw_ready <= !aw_hs;                          // drop after capture
               if (aw_hs)
                  aw_state <= bram_rsp_pkg::AW_CAPTURED;
            end
            bram_rsp_pkg::AW_CAPTURED:
            begin
               if (b_hs)                                      // burst fully answered
               begin
                  aw_state   <= bram_rsp_pkg::AW_IDLE;
                  o_aw_ready <= 1'b1;
               end
            end
         endcase
      end
   end

   // id goes straight into the B payload, held until B is taken
   always_ff @(posedge i_clk)
   begin
      if (aw_hs)
      begin
         o_b.id   <= i_aw.id;
         o_b.resp <= `BRAM_RSP_RESP_OKAY;
      end
   end

   // ----------------------------------------------------------------------
   // W and B machine
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (!i_reset_n)
      begin
         wr_state  <= bram_rsp_pkg::WR_IDLE;
         o_w_ready <= 1'b0;
         o_b_valid <= 1'b0;
      end
      else
      begin
         case (wr_state)
            bram_rsp_pkg::WR_IDLE, bram_rsp_pkg::WR_CAPTURE:
            begin
               if (w_hs)                                      // data phase starts
               begin
                  wr_state  <= i_w.last ? bram_rsp_pkg::WR_RSP : bram_rsp_pkg::WR_DATA;
                  o_w_ready <= !i_w.last;
               end
               else
               begin
                  if (aw_hs)
                     wr_state <= bram_rsp_pkg::WR_CAPTURE;
                  // without an address, any read keeps W off
                  o_w_ready <= (aw_hs || (wr_state == bram_rsp_pkg::WR_CAPTURE)) ?
                               !clash : !i_rd_busy.busy;
               end
            end
            bram_rsp_pkg::WR_DATA:
            begin
               if (w_hs && i_w.last)
               begin
                  wr_state  <= bram_rsp_pkg::WR_RSP;
                  o_w_ready <= 1'b0;
               end
            end
            bram_rsp_pkg::WR_RSP:
            begin
               if (b_hs)
               begin
                  wr_state  <= bram_rsp_pkg::WR_IDLE;
                  o_b_valid <= 1'b0;
               end
               else
                  o_b_valid <= 1'b1;                          // last beat in memory by now
            end
         endcase
      end
   end

   // ----------------------------------------------------------------------
   // address increment and memory port
   // ----------------------------------------------------------------------
   always_ff @(posedge i_clk)
   begin
      if (w_hs)
         wr_addr <= beat_addr + 1'b1;
      else if (aw_hs)
         wr_addr <= beat_addr;
   end

   always_ff @(posedge i_clk)
   begin
      if (w_hs)
      begin
         o_mem_wr.addr <= beat_addr;
         o_mem_wr.data <= i_w.data;
         o_mem_wr.strb <= i_w.strb;
      end
      if (!i_reset_n)
         o_mem_wr.en <= 1'b0;
      else
         o_mem_wr.en <= w_hs;                                 // one cycle after the beat
   end

   // first W beat needs its AW now or already captured
   a_w_after_aw : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (w_hs && (wr_state == bram_rsp_pkg::WR_IDLE)) |->
      (aw_hs || (aw_state == bram_rsp_pkg::AW_CAPTURED)));

   a_b_hold : assert property (@(posedge i_clk) disable iff (!i_reset_n)
      (o_b_valid && !i_b_ready) |=> (o_b_valid && $stable(o_b)));

endmodule
